// ==== Makefile ====
# Verilator flow for the AES-128 engine

VERILATOR  ?= verilator
TOP        ?= aesTb
RTL_TOP    ?= aesTop
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing
LINT_FLAGS ?=
JOBS       ?= 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "Simulation ended without passing"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
+incdir+tb
logic/aesPkg.sv
logic/aesSbox.sv
logic/aesKeyExpand.sv
logic/aesRound.sv
logic/aesKeyRegs.sv
logic/aesCore.sv
logic/aesTop.sv
tb/aesTb.sv

// ==== logic/aesCore.sv ====
`timescale 1ns/10ps

module aesCore import aesPkg::*;
(
        input  logic      clk,
        input  logic      rstN,
        input  logic      start,
        input  aesState_t block,
        input  aesState_t cipherKey,
        input  logic      keyValid,
        output logic      busy,
        output logic      done,
        output aesState_t result
);

        logic                    accept;
        logic                    lastRound;
        logic [aesRoundBits-1:0] roundCnt;
        aesState_t               stateReg;
        aesState_t               nextState;
        aesState_t               roundKey;

        assign accept    = start && keyValid && !busy;
        assign lastRound = (roundCnt == aesRoundBits'(aesNumRounds));

        ////////////////////////////////////////////////////////////
        // Datapath
        ////////////////////////////////////////////////////////////

        aesKeyExpand keyExpand0 (
                .clk      (clk),
                .rstN     (rstN),
                .load     (accept),
                .advance  (busy),
                .key      (cipherKey),
                .roundKey (roundKey)
        );

        aesRound round0 (
                .stateIn   (stateReg),
                .roundKey  (roundKey),
                .lastRound (lastRound),
                .stateOut  (nextState)
        );

        // Initial AddRoundKey on accept, then one round per clock
        always_ff @(posedge clk)
        begin
                if (accept)
                        stateReg <= block ^ cipherKey;
                else if (busy)
                        stateReg <= nextState;
        end

        ////////////////////////////////////////////////////////////
        // Round control
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                begin
                        busy     <= 1'b0;
                        done     <= 1'b0;
                        roundCnt <= '0;
                end
                else
                begin
                        done <= 1'b0;
                        if (accept)
                        begin
                                busy     <= 1'b1;
                                roundCnt <= aesRoundBits'(1);
                        end
                        else if (busy)
                        begin
                                if (lastRound)
                                begin
                                        busy     <= 1'b0;
                                        done     <= 1'b1;
                                        roundCnt <= '0;
                                end
                                else
                                        roundCnt <= roundCnt + 1'b1;
                        end
                end
        end

        // Ciphertext held until the next block finishes
        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                        result <= '0;
                else if (busy && lastRound)
                        result <= nextState;
        end

endmodule

// ==== logic/aesKeyExpand.sv ====
`timescale 1ns/10ps

module aesKeyExpand import aesPkg::*;
(
        input  logic      clk,
        input  logic      rstN,
        input  logic      load,
        input  logic      advance,
        input  aesState_t key,
        output aesState_t roundKey
);

        aesState_t       curKey;
        aesState_t       nextKey;
        aesByte_t        rcon;
        aesByte_t [0:3]  rotBytes;
        aesByte_t [0:3]  subBytes;
        aesWord_t        tempWord;

        ////////////////////////////////////////////////////////////
        // Next round key
        ////////////////////////////////////////////////////////////

        // RotWord on the last column
        assign rotBytes = {curKey.c3.b1, curKey.c3.b2, curKey.c3.b3, curKey.c3.b0};

        for (genvar i = 0; i < 4; i++)
        begin : gSubWord
                aesSbox sbox0 (
                        .in  (rotBytes[i]),
                        .out (subBytes[i])
                );
        end

        assign tempWord = aesWord_t'(subBytes) ^ {rcon, 24'h000000};

        always_comb
        begin
                nextKey.c0 = curKey.c0 ^ tempWord;
                nextKey.c1 = curKey.c1 ^ nextKey.c0;
                nextKey.c2 = curKey.c2 ^ nextKey.c1;
                nextKey.c3 = curKey.c3 ^ nextKey.c2;
        end

        // Key for the round being computed
        assign roundKey = nextKey;

        ////////////////////////////////////////////////////////////
        // Registers
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (load)
                        curKey <= key;
                else if (advance)
                        curKey <= nextKey;
        end

        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                        rcon <= aesRconInit;
                else if (load)
                        rcon <= aesRconInit;
                else if (advance)
                        rcon <= aesXtime(rcon);
        end

endmodule

// ==== logic/aesKeyRegs.sv ====
`timescale 1ns/10ps

module aesKeyRegs import aesPkg::*;
(
        input  logic      clk,
        input  logic      rstN,
        input  logic      keyWrite,
        input  aesState_t key,
        input  logic      busy,
        output aesState_t cipherKey,
        output logic      keyValid
);

        logic keyAccept;

        // Key must not change under a running block
        assign keyAccept = keyWrite && !busy;

        ////////////////////////////////////////////////////////////
        // Key storage
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (keyAccept)
                        cipherKey <= key;
        end

        // Stays set until reset
        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                        keyValid <= 1'b0;
                else if (keyAccept)
                        keyValid <= 1'b1;
        end

endmodule

// ==== logic/aesPkg.sv ====
package aesPkg;

        ////////////////////////////////////////////////////////////
        // Data types
        ////////////////////////////////////////////////////////////

        typedef logic [7:0] aesByte_t;

        // One state column or key word, b0 is row 0
        typedef struct packed {
                aesByte_t b0;
                aesByte_t b1;
                aesByte_t b2;
                aesByte_t b3;
        } aesWord_t;

        // FIPS-197 byte order, c0.b0 is the first input byte
        typedef struct packed {
                aesWord_t c0;
                aesWord_t c1;
                aesWord_t c2;
                aesWord_t c3;
        } aesState_t;

        ////////////////////////////////////////////////////////////
        // AES-128 constants
        ////////////////////////////////////////////////////////////

        localparam int unsigned aesNumRounds = 10;
        localparam int unsigned aesRoundBits = 4;
        localparam aesByte_t    aesRconInit  = 8'h01;

        // Multiply by x modulo the AES polynomial
        function automatic aesByte_t aesXtime(input aesByte_t a);
                return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
        endfunction

endpackage

// ==== logic/aesRound.sv ====
`timescale 1ns/10ps

module aesRound import aesPkg::*;
(
        input  aesState_t stateIn,
        input  aesState_t roundKey,
        input  logic      lastRound,
        output aesState_t stateOut
);

        // Byte 4*col+row, byte 0 is the most significant
        aesByte_t [0:15] inBytes;
        aesByte_t [0:15] subBytes;
        aesByte_t [0:15] shiftBytes;
        aesByte_t [0:15] mixBytes;

        assign inBytes = stateIn;

        ////////////////////////////////////////////////////////////
        // SubBytes
        ////////////////////////////////////////////////////////////

        for (genvar i = 0; i < 16; i++)
        begin : gSubBytes
                aesSbox sbox0 (
                        .in  (inBytes[i]),
                        .out (subBytes[i])
                );
        end

        ////////////////////////////////////////////////////////////
        // ShiftRows and MixColumns
        ////////////////////////////////////////////////////////////

        for (genvar c = 0; c < 4; c++)
        begin : gColumn
                aesByte_t a0;
                aesByte_t a1;
                aesByte_t a2;
                aesByte_t a3;
                aesByte_t x0;
                aesByte_t x1;
                aesByte_t x2;
                aesByte_t x3;

                // Row r moves left by r columns
                for (genvar r = 0; r < 4; r++)
                begin : gRow
                        assign shiftBytes[4*c+r] = subBytes[4*((c+r)%4)+r];
                end

                assign a0 = shiftBytes[4*c];
                assign a1 = shiftBytes[4*c+1];
                assign a2 = shiftBytes[4*c+2];
                assign a3 = shiftBytes[4*c+3];

                assign x0 = aesXtime(a0);
                assign x1 = aesXtime(a1);
                assign x2 = aesXtime(a2);
                assign x3 = aesXtime(a3);

                // Rows of the 02 03 01 01 circulant
                assign mixBytes[4*c]   = x0 ^ x1 ^ a1 ^ a2 ^ a3;
                assign mixBytes[4*c+1] = a0 ^ x1 ^ x2 ^ a2 ^ a3;
                assign mixBytes[4*c+2] = a0 ^ a1 ^ x2 ^ x3 ^ a3;
                assign mixBytes[4*c+3] = x0 ^ a0 ^ a1 ^ a2 ^ x3;
        end

        // No MixColumns in round ten
        assign stateOut = aesState_t'((lastRound ? shiftBytes : mixBytes) ^ roundKey);

endmodule

// ==== logic/aesSbox.sv ====
`timescale 1ns/10ps

module aesSbox import aesPkg::*;
(
        input  aesByte_t in,
        output aesByte_t out
);

        // Forward S-box, row picked by the high nibble
        localparam aesByte_t [0:15] sboxRows [16] = '{
                128'h637c777bf26b6fc53001672bfed7ab76,
                128'hca82c97dfa5947f0add4a2af9ca472c0,
                128'hb7fd9326363ff7cc34a5e5f171d83115,
                128'h04c723c31896059a071280e2eb27b275,
                128'h09832c1a1b6e5aa0523bd6b329e32f84,
                128'h53d100ed20fcb15b6acbbe394a4c58cf,
                128'hd0efaafb434d338545f9027f503c9fa8,
                128'h51a3408f929d38f5bcb6da2110fff3d2,
                128'hcd0c13ec5f974417c4a77e3d645d1973,
                128'h60814fdc222a908846eeb814de5e0bdb,
                128'he0323a0a4906245cc2d3ac629195e479,
                128'he7c8376d8dd54ea96c56f4ea657aae08,
                128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
                128'h703eb5664803f60e613557b986c11d9e,
                128'he1f8981169d98e949b1e87e9ce5528df,
                128'h8ca1890dbfe6426841992d0fb054bb16
        };

        assign out = sboxRows[in[7:4]][in[3:0]];

endmodule

// ==== logic/aesTop.sv ====
`timescale 1ns/10ps

module aesTop import aesPkg::*;
(
        input  logic      clk,
        input  logic      rstN,
        input  logic      keyWrite,
        input  aesState_t key,
        input  logic      start,
        input  aesState_t block,
        output logic      busy,
        output logic      done,
        output aesState_t result
);

        aesState_t cipherKey;
        logic      keyValid;

        ////////////////////////////////////////////////////////////
        // Key registers and engine
        ////////////////////////////////////////////////////////////

        aesKeyRegs keyRegs0 (
                .clk       (clk),
                .rstN      (rstN),
                .keyWrite  (keyWrite),
                .key       (key),
                .busy      (busy),
                .cipherKey (cipherKey),
                .keyValid  (keyValid)
        );

        aesCore core0 (
                .clk       (clk),
                .rstN      (rstN),
                .start     (start),
                .block     (block),
                .cipherKey (cipherKey),
                .keyValid  (keyValid),
                .busy      (busy),
                .done      (done),
                .result    (result)
        );

endmodule

// ==== tb/aesRef.svh ====
`ifndef AES_REF_SVH
`define AES_REF_SVH

// Multiply by x, reduced by x^8+x^4+x^3+x+1
function automatic aesByte_t mulX(input aesByte_t a);
        aesByte_t r;
        r = a << 1;
        if (a[7])
                r = r ^ 8'h1b;
        return r;
endfunction

function automatic aesByte_t gfMul(input aesByte_t a, input aesByte_t b);
        aesByte_t p;
        aesByte_t x;
        aesByte_t y;
        int       i;
        p = 8'h00;
        x = a;
        y = b;
        for (i = 0; i < 8; i++)
        begin
                if (y[0])
                        p = p ^ x;
                x = mulX(x);
                y = y >> 1;
        end
        return p;
endfunction

// a^254 is the inverse, and maps 0 to 0
function automatic aesByte_t invertByte(input aesByte_t a);
        aesByte_t r;
        aesByte_t base;
        int       e;
        r    = 8'h01;
        base = a;
        e    = 254;
        while (e != 0)
        begin
                if (e % 2 == 1)
                        r = gfMul(r, base);
                base = gfMul(base, base);
                e    = e / 2;
        end
        return r;
endfunction

// Inverse followed by the affine map
function automatic aesByte_t substByte(input aesByte_t a);
        aesByte_t rot;
        aesByte_t s;
        int       i;
        s   = invertByte(a);
        rot = s;
        for (i = 0; i < 4; i++)
        begin
                rot = {rot[6:0], rot[7]};
                s   = s ^ rot;
        end
        return s ^ 8'h63;
endfunction

function automatic aesState_t aesEncrypt(input aesState_t key, input aesState_t plain);
        logic [127:0] kv;
        logic [127:0] pv;
        logic [127:0] outV;
        logic [31:0]  w [44];
        logic [31:0]  tw;
        aesByte_t     s [16];
        aesByte_t     t [16];
        aesByte_t     rc;
        aesByte_t     a0;
        aesByte_t     a1;
        aesByte_t     a2;
        aesByte_t     a3;
        int           i;
        int           c;
        int           r;
        int           rnd;
        kv = key;
        pv = plain;

        // Key schedule
        for (i = 0; i < 4; i++)
                w[i] = kv[127-32*i -: 32];
        rc = 8'h01;
        for (i = 4; i < 44; i++)
        begin
                tw = w[i-1];
                if (i % 4 == 0)
                begin
                        tw = {tw[23:0], tw[31:24]};
                        tw = {substByte(tw[31:24]), substByte(tw[23:16]),
                              substByte(tw[15:8]), substByte(tw[7:0])};
                        tw = tw ^ {rc, 24'h000000};
                        rc = mulX(rc);
                end
                w[i] = w[i-4] ^ tw;
        end

        for (i = 0; i < 16; i++)
                s[i] = pv[127-8*i -: 8];

        for (rnd = 0; rnd <= 10; rnd++)
        begin
                if (rnd > 0)
                begin
                        for (i = 0; i < 16; i++)
                                t[i] = substByte(s[i]);
                        for (c = 0; c < 4; c++)
                                for (r = 0; r < 4; r++)
                                        s[4*c+r] = t[4*((c+r)%4)+r];
                        if (rnd < 10)
                        begin
                                for (c = 0; c < 4; c++)
                                begin
                                        a0 = s[4*c];
                                        a1 = s[4*c+1];
                                        a2 = s[4*c+2];
                                        a3 = s[4*c+3];
                                        s[4*c]   = gfMul(a0, 8'h02) ^ gfMul(a1, 8'h03) ^ a2 ^ a3;
                                        s[4*c+1] = a0 ^ gfMul(a1, 8'h02) ^ gfMul(a2, 8'h03) ^ a3;
                                        s[4*c+2] = a0 ^ a1 ^ gfMul(a2, 8'h02) ^ gfMul(a3, 8'h03);
                                        s[4*c+3] = gfMul(a0, 8'h03) ^ a1 ^ a2 ^ gfMul(a3, 8'h02);
                                end
                        end
                end
                for (i = 0; i < 16; i++)
                        s[i] = s[i] ^ w[4*rnd + i/4][31-8*(i%4) -: 8];
        end

        for (i = 0; i < 16; i++)
                outV[127-8*i -: 8] = s[i];
        return aesState_t'(outV);
endfunction

`endif

// ==== tb/aesTb.sv ====
`timescale 1ns/10ps

module aesTb import aesPkg::*;
();

        localparam int clkHalf     = 4;
        localparam int resetCycles = 16;
        localparam int waitLimit   = 40;
        localparam int numRandom   = 200;

        localparam aesState_t katKey    = 128'h000102030405060708090a0b0c0d0e0f;
        localparam aesState_t katPlain  = 128'h00112233445566778899aabbccddeeff;
        localparam aesState_t katCipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

        logic      clk;
        logic      rstN;
        logic      keyWrite;
        aesState_t key;
        logic      start;
        aesState_t block;
        logic      busy;
        logic      done;
        aesState_t result;

        int        cycleCnt = 0;
        int        lastDue;
        aesState_t modelKey;
        aesState_t heldResult = '0;
        aesState_t expQ [$];
        int        dueQ [$];

        `include "aesRef.svh"

        aesTop dut0 (
                .clk      (clk),
                .rstN     (rstN),
                .keyWrite (keyWrite),
                .key      (key),
                .start    (start),
                .block    (block),
                .busy     (busy),
                .done     (done),
                .result   (result)
        );

        initial
        begin
                clk = 1'b0;
                forever
                        #clkHalf clk = ~clk;
        end

        always @(posedge clk)
                cycleCnt <= cycleCnt + 1;

        ////////////////////////////////////////////////////////////
        // Compare tasks
        ////////////////////////////////////////////////////////////

        task automatic stopOnError();
                $display("TEST FAILED");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic checkBlock(input aesState_t got, input aesState_t exp, input string what);
                if (got !== exp)
                begin
                        $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
                        stopOnError();
                end
        endtask

        task automatic checkLevel(input logic got, input logic exp, input string what);
                if (got !== exp)
                begin
                        $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
                        stopOnError();
                end
        endtask

        // Outputs sampled mid-cycle against the start schedule
        always @(negedge clk)
        begin : compareProc
                logic expDone;
                logic expBusy;
                expDone = 1'b0;
                expBusy = 1'b0;
                if (dueQ.size() != 0)
                begin
                        expDone = (dueQ[0] == cycleCnt);
                        expBusy = (cycleCnt > dueQ[0] - 11) && (cycleCnt < dueQ[0]);
                end
                if (rstN)
                begin
                        checkLevel(done, expDone, "done");
                        checkLevel(busy, expBusy, "busy");
                        if (done)
                        begin
                                checkBlock(result, expQ[0], "ciphertext");
                                heldResult = expQ[0];
                                void'(expQ.pop_front());
                                void'(dueQ.pop_front());
                        end
                        else
                                checkBlock(result, heldResult, "held result");
                end
        end

        ////////////////////////////////////////////////////////////
        // Stimulus tasks
        ////////////////////////////////////////////////////////////

        task automatic stepCycle();
                @(posedge clk);
                #1;
        endtask

        function automatic aesState_t randState();
                return aesState_t'({$urandom, $urandom, $urandom, $urandom});
        endfunction

        task automatic pulseKeyWrite(input aesState_t k);
                keyWrite = 1'b1;
                key      = k;
                stepCycle();
                keyWrite = 1'b0;
        endtask

        task automatic loadKey(input aesState_t k);
                pulseKeyWrite(k);
                modelKey = k;
        endtask

        task automatic pulseStart(input aesState_t pt);
                start = 1'b1;
                block = pt;
                stepCycle();
                start = 1'b0;
        endtask

        // Start that must be accepted with done due 11 edges later
        task automatic launchBlock(input aesState_t pt, input aesState_t exp);
                lastDue = cycleCnt + aesNumRounds + 1;
                expQ.push_back(exp);
                dueQ.push_back(lastDue);
                pulseStart(pt);
        endtask

        task automatic waitIdle(input string what);
                int n;
                for (n = 0; n < waitLimit && (busy || expQ.size() != 0); n++)
                        stepCycle();
                if (busy || expQ.size() != 0)
                begin
                        $display("Timeout: %s did not finish within %0d cycles", what, waitLimit);
                        stopOnError();
                end
        endtask

        task automatic waitForCycle(input int target, input string what);
                int n;
                for (n = 0; n < waitLimit && cycleCnt < target; n++)
                        stepCycle();
                if (cycleCnt != target)
                begin
                        $display("Timeout: never reached the cycle of %s", what);
                        stopOnError();
                end
        endtask

        ////////////////////////////////////////////////////////////
        // Behavior sequences
        ////////////////////////////////////////////////////////////

        initial
        begin : mainSeq
                aesState_t pt;
                aesState_t oldKey;
                int        i;

                void'($urandom(36090));
                rstN     = 1'b0;
                keyWrite = 1'b0;
                key      = '0;
                start    = 1'b0;
                block    = '0;
                modelKey = '0;
                repeat (resetCycles)
                        @(posedge clk);
                #1;
                rstN = 1'b1;
                checkLevel(busy, 1'b0, "busy after reset");
                checkLevel(done, 1'b0, "done after reset");
                checkBlock(result, '0, "result after reset");

                // Start with no key loaded
                pulseStart(randState());
                repeat (30)
                        stepCycle();

                // Known answer on both the reference and the DUT
                checkBlock(aesEncrypt(katKey, katPlain), katCipher, "reference known answer");
                loadKey(katKey);
                launchBlock(katPlain, katCipher);
                waitIdle("known-answer block");

                // Latency and pulse width
                pt = randState();
                launchBlock(pt, aesEncrypt(modelKey, pt));
                for (i = 1; i <= 10; i++)
                begin
                        checkLevel(busy, 1'b1, "busy during rounds");
                        checkLevel(done, 1'b0, "done during rounds");
                        stepCycle();
                end
                checkLevel(done, 1'b1, "done 10 edges after start");
                checkLevel(busy, 1'b0, "busy in done cycle");
                stepCycle();
                checkLevel(done, 1'b0, "done after one cycle");

                for (i = 0; i < numRandom; i++)
                begin
                        if (i % 4 == 0)
                                loadKey(randState());
                        pt = randState();
                        launchBlock(pt, aesEncrypt(modelKey, pt));
                        waitIdle("random block");
                end

                // Strobes while busy have no effect
                oldKey = randState();
                loadKey(oldKey);
                pt = randState();
                launchBlock(pt, aesEncrypt(oldKey, pt));
                repeat (3)
                        stepCycle();
                pulseKeyWrite(randState());
                pulseStart(randState());
                waitIdle("block with ignored strobes");
                pt = randState();
                launchBlock(pt, aesEncrypt(oldKey, pt));
                waitIdle("block after ignored key write");

                // Next start in each done cycle
                loadKey(randState());
                for (i = 0; i < 4; i++)
                begin
                        pt = randState();
                        launchBlock(pt, aesEncrypt(modelKey, pt));
                        waitForCycle(lastDue, "back-to-back done");
                        checkLevel(done, 1'b1, "done before back-to-back start");
                end
                pt = randState();
                launchBlock(pt, aesEncrypt(modelKey, pt));
                waitIdle("last back-to-back block");

                $display("TEST OK");
                $finish;
        end

endmodule
